// File: Bender.yml
package:
  name: etx

sources:
  - hw/etx_pkt_pkg.sv
  - hw/etx_cfg_pkg.sv
  - hw/etx_fifo.sv
  - hw/etx_cfg.sv
  - hw/etx_arbiter.sv
  - hw/etx_top.sv
  - target: test
    files:
      - testbench/etx_sva.sv
      - testbench/tb_etx.sv

// File: flist.f
hw/etx_pkt_pkg.sv
hw/etx_cfg_pkg.sv
hw/etx_fifo.sv
hw/etx_cfg.sv
hw/etx_arbiter.sv
hw/etx_top.sv
testbench/etx_sva.sv
testbench/tb_etx.sv

// File: hw/etx_arbiter.sv
// ##########################################################################
// eMesh transmit arbiter
// Fixed priority select (write, read request, read response), ctrlmode
// substitution for slave packets and the registered link output stage
// ##########################################################################

`timescale 1ns/1ns

module etx_arbiter (
  input  logic                                tx_lclk_div4,
  input  logic                                reset,
  // Configuration
  input  logic                                cfg_bp,
  input  logic [etx_pkt_pkg::ctrlmode_w-1:0]  cfg_ctrlmode,
  // FIFO heads
  input  logic                                txwr_empty,
  input  logic [etx_pkt_pkg::pw-1:0]          txwr_head,
  input  logic                                txrd_empty,
  input  logic [etx_pkt_pkg::pw-1:0]          txrd_head,
  input  logic                                txrr_empty,
  input  logic [etx_pkt_pkg::pw-1:0]          txrr_head,
  // Link back-pressure
  input  logic                                etx_wait,
  input  logic                                etx_wr_wait,
  input  logic                                etx_rd_wait,
  // FIFO pops, also the forward pulses
  output logic                                txwr_pop,
  output logic                                txrd_pop,
  output logic                                txrr_pop,
  // Link output
  output logic                                etx_access,
  output logic [etx_pkt_pkg::pw-1:0]          etx_packet,
  output logic                                etx_rr
);

  import etx_pkt_pkg::*;

  logic          wr_ready;
  logic          rd_ready;
  logic          rr_ready;
  logic          out_free;
  logic          any_pop;
  chan_e         grant;
  logic [pw-1:0] sel_packet;

  // Overwrite ctrlmode field when bypass is on
  function automatic logic [pw-1:0] apply_ctrlmode(
    input logic [pw-1:0]         pkt,
    input logic                  bp,
    input logic [ctrlmode_w-1:0] mode
  );
    logic [pw-1:0] res;
    res = pkt;
    if (bp)
      res[ctrlmode_lsb +: ctrlmode_w] = mode;
    return res;
  endfunction

  // ########################################################################
  // Priority select
  // ########################################################################

  // Read responses share the write path, so etx_wr_wait blocks them too
  assign wr_ready = ~txwr_empty & ~etx_wr_wait;
  assign rd_ready = ~txrd_empty & ~etx_rd_wait & ~wr_ready;
  assign rr_ready = ~txrr_empty & ~etx_wr_wait & ~wr_ready & ~rd_ready;

  always_comb
  begin
    if (wr_ready)
      grant = chan_wr;
    else if (rd_ready)
      grant = chan_rd;
    else if (rr_ready)
      grant = chan_rr;
    else
      grant = chan_none;
  end

  // Output stage free when empty or being accepted this cycle
  assign out_free = ~etx_access | ~etx_wait;

  // One-hot by construction of the grant
  assign txwr_pop = out_free & (grant == chan_wr);
  assign txrd_pop = out_free & (grant == chan_rd);
  assign txrr_pop = out_free & (grant == chan_rr);
  assign any_pop  = txwr_pop | txrd_pop | txrr_pop;

  // Packet toward the output register, read responses untouched
  always_comb
  begin
    case (grant)
      chan_wr: sel_packet = apply_ctrlmode(txwr_head, cfg_bp, cfg_ctrlmode);
      chan_rd: sel_packet = apply_ctrlmode(txrd_head, cfg_bp, cfg_ctrlmode);
      chan_rr: sel_packet = txrr_head;
      default: sel_packet = '0;
    endcase
  end

  // ########################################################################
  // Output register
  // ########################################################################

  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      etx_access <= 1'b0;
      etx_rr     <= 1'b0;
      etx_packet <= '0;
    end
    else if (any_pop)
    begin
      etx_access <= 1'b1;
      etx_rr     <= txrr_pop;
      etx_packet <= sel_packet;
    end
    else if (~etx_wait)
      // Accepted with nothing behind it
      etx_access <= 1'b0;
  end

endmodule

// File: hw/etx_cfg.sv
// ##########################################################################
// APB configuration slave for the transmit path
// Control register (bypass, ctrlmode) and per-channel packet counters
// Counters count forwarded packets, an APB write clears them
// ##########################################################################

`timescale 1ns/1ns

module etx_cfg (
  input  logic                                tx_lclk_div4,
  input  logic                                reset,
  // APB slave
  input  logic [etx_cfg_pkg::apb_aw-1:0]      paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [etx_cfg_pkg::apb_dw-1:0]      pwdata,
  output logic [etx_cfg_pkg::apb_dw-1:0]      prdata,
  output logic                                pready,
  // Forward pulses from the arbiter
  input  logic                                fwd_wr,
  input  logic                                fwd_rd,
  input  logic                                fwd_rr,
  // Configuration toward the arbiter
  output logic                                cfg_bp,
  output logic [etx_pkt_pkg::ctrlmode_w-1:0]  cfg_ctrlmode
);

  import etx_pkt_pkg::*;
  import etx_cfg_pkg::*;

  logic              apb_wr;
  logic              apb_rd;
  logic [2:0]        fwd;
  logic [2:0]        cnt_clr;
  logic [apb_dw-1:0] cnt [3];
  logic [apb_dw-1:0] ctrl_rdata;

  // No wait states
  assign pready = 1'b1;

  // Access phase strobes
  assign apb_wr = psel & penable & pwrite;
  assign apb_rd = psel & penable & ~pwrite;

  // ########################################################################
  // Control register
  // ########################################################################

  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      cfg_bp       <= 1'b0;
      cfg_ctrlmode <= '0;
    end
    else if (apb_wr && (paddr == reg_ctrl))
    begin
      cfg_bp       <= pwdata[ctrl_bp_bit];
      cfg_ctrlmode <= pwdata[ctrl_mode_lsb +: ctrlmode_w];
    end
  end

  // ########################################################################
  // Packet counters, index 0 wr, 1 rd, 2 rr
  // ########################################################################

  assign fwd = {fwd_rr, fwd_rd, fwd_wr};

  // Any write to a counter address clears it
  assign cnt_clr[0] = apb_wr & (paddr == reg_cnt_wr);
  assign cnt_clr[1] = apb_wr & (paddr == reg_cnt_rd);
  assign cnt_clr[2] = apb_wr & (paddr == reg_cnt_rr);

  always_ff @(posedge tx_lclk_div4)
  begin
    for (int i = 0; i < 3; i++)
    begin
      if (reset || cnt_clr[i])
        cnt[i] <= '0;
      else if (fwd[i])
        cnt[i] <= cnt[i] + 1'b1;
    end
  end

  // ########################################################################
  // Read mux, combinational during access phase
  // ########################################################################

  always_comb
  begin
    ctrl_rdata = '0;
    ctrl_rdata[ctrl_bp_bit] = cfg_bp;
    ctrl_rdata[ctrl_mode_lsb +: ctrlmode_w] = cfg_ctrlmode;
  end

  always_comb
  begin
    prdata = '0;
    if (apb_rd)
    begin
      case (paddr)
        reg_ctrl:   prdata = ctrl_rdata;
        reg_cnt_wr: prdata = cnt[0];
        reg_cnt_rd: prdata = cnt[1];
        reg_cnt_rr: prdata = cnt[2];
        default:    prdata = '0;
      endcase
    end
  end

endmodule

// File: hw/etx_cfg_pkg.sv
// ##########################################################################
// eMesh transmit configuration definitions
// APB widths, register map and control register bit positions
// ##########################################################################

package etx_cfg_pkg;

  // APB bus widths
  localparam int apb_aw = 4;
  localparam int apb_dw = 32;

  // ########################################################################
  // Register map, byte addresses
  // ########################################################################

  // Control, bypass bit and ctrlmode value
  localparam logic [apb_aw-1:0] reg_ctrl = 'h0;

  // Forwarded write packets, read only, cleared by any write
  localparam logic [apb_aw-1:0] reg_cnt_wr = 'h4;

  // Forwarded read requests
  localparam logic [apb_aw-1:0] reg_cnt_rd = 'h8;

  // Forwarded read responses
  localparam logic [apb_aw-1:0] reg_cnt_rr = 'hc;

  // ########################################################################
  // Control register fields
  // ########################################################################

  // Bypass, replace ctrlmode of outgoing slave packets
  localparam int ctrl_bp_bit = 0;

  // Low bit of the 4-bit ctrlmode value
  localparam int ctrl_mode_lsb = 4;

endpackage

// File: hw/etx_fifo.sv
// ##########################################################################
// Synchronous packet FIFO for one transmit channel
// Circular buffer with read and write pointers and an occupancy count
// ##########################################################################

`timescale 1ns/1ns

module etx_fifo #(
  parameter int depth = 4
) (
  input  logic                         tx_lclk_div4,
  input  logic                         reset,
  input  logic                         push,
  input  logic [etx_pkt_pkg::pw-1:0]   push_packet,
  input  logic                         pop,
  output logic [etx_pkt_pkg::pw-1:0]   head_packet,
  output logic                         empty,
  output logic                         full
);

  import etx_pkt_pkg::*;

  // Pointer and count widths, depth is a power of two
  localparam int aw = $clog2(depth);
  localparam int cnt_w = aw + 1;

  logic [pw-1:0]    mem [depth];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Push while full is dropped, pop while empty is ignored
  assign wr_en = push & ~full;
  assign rd_en = pop & ~empty;

  assign empty = (count == '0);
  assign full  = (count == cnt_w'(depth));

  // Head is visible as soon as it is written
  assign head_packet = mem[rd_ptr];

  // Storage
  always_ff @(posedge tx_lclk_div4)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_packet;
  end

  // Pointers wrap on their own width
  always_ff @(posedge tx_lclk_div4)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leaves count unchanged
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/etx_pkt_pkg.sv
// ##########################################################################
// eMesh transmit packet definitions
// Packet width, ctrlmode field position and the arbiter grant encoding
// ##########################################################################

package etx_pkt_pkg;

  // ########################################################################
  // Packet layout
  // ########################################################################

  // Full eMesh packet, as pushed by the sources and sent to the link
  localparam int pw = 104;

  // Packet low byte holds write flag, datamode and ctrlmode
  //   bit 0      write
  //   bits 3:1   datamode / access type
  //   bits 7:4   ctrlmode
  // Remaining bits carry dstaddr, data and srcaddr untouched by this block

  // Start of the ctrlmode field
  localparam int ctrlmode_lsb = 4;

  // Width of the ctrlmode field
  localparam int ctrlmode_w = 4;

  // ########################################################################
  // Arbiter grant
  // ########################################################################

  // Which FIFO the arbiter selects this cycle
  //   chan_wr   host write, highest priority
  //   chan_rd   host read request
  //   chan_rr   read response, lowest priority
  typedef enum logic [1:0] {
    chan_none,
    chan_wr,
    chan_rd,
    chan_rr
  } chan_e;

endpackage

// File: hw/etx_top.sv
// ##########################################################################
// eMesh transmit top level
// Three channel FIFOs, APB configuration block and the arbiter
// ##########################################################################

`timescale 1ns/1ns

module etx_top (
  input  logic                            tx_lclk_div4,
  input  logic                            reset,
  // Packet sources
  input  logic                            txwr_push,
  input  logic [etx_pkt_pkg::pw-1:0]      txwr_in,
  output logic                            txwr_full,
  input  logic                            txrd_push,
  input  logic [etx_pkt_pkg::pw-1:0]      txrd_in,
  output logic                            txrd_full,
  input  logic                            txrr_push,
  input  logic [etx_pkt_pkg::pw-1:0]      txrr_in,
  output logic                            txrr_full,
  // Link side
  output logic                            etx_access,
  output logic [etx_pkt_pkg::pw-1:0]      etx_packet,
  output logic                            etx_rr,
  input  logic                            etx_wait,
  input  logic                            etx_wr_wait,
  input  logic                            etx_rd_wait,
  // APB slave
  input  logic [etx_cfg_pkg::apb_aw-1:0]  paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [etx_cfg_pkg::apb_dw-1:0]  pwdata,
  output logic [etx_cfg_pkg::apb_dw-1:0]  prdata,
  output logic                            pready
);

  import etx_pkt_pkg::*;

  // FIFO heads and flags
  logic                  txwr_empty;
  logic                  txrd_empty;
  logic                  txrr_empty;
  logic [pw-1:0]         txwr_head;
  logic [pw-1:0]         txrd_head;
  logic [pw-1:0]         txrr_head;
  // Pops, also counted in etx_cfg
  logic                  txwr_pop;
  logic                  txrd_pop;
  logic                  txrr_pop;
  // Configuration
  logic                  cfg_bp;
  logic [ctrlmode_w-1:0] cfg_ctrlmode;

  // Channel FIFOs
  etx_fifo u_wr_fifo (
    .tx_lclk_div4, .reset,
    .push(txwr_push), .push_packet(txwr_in), .pop(txwr_pop),
    .head_packet(txwr_head), .empty(txwr_empty), .full(txwr_full)
  );

  etx_fifo u_rd_fifo (
    .tx_lclk_div4, .reset,
    .push(txrd_push), .push_packet(txrd_in), .pop(txrd_pop),
    .head_packet(txrd_head), .empty(txrd_empty), .full(txrd_full)
  );

  etx_fifo u_rr_fifo (
    .tx_lclk_div4, .reset,
    .push(txrr_push), .push_packet(txrr_in), .pop(txrr_pop),
    .head_packet(txrr_head), .empty(txrr_empty), .full(txrr_full)
  );

  // Register block
  etx_cfg u_cfg (
    .tx_lclk_div4, .reset,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
    .fwd_wr(txwr_pop), .fwd_rd(txrd_pop), .fwd_rr(txrr_pop),
    .cfg_bp, .cfg_ctrlmode
  );

  // Arbiter and output stage
  etx_arbiter u_arbiter (
    .tx_lclk_div4, .reset,
    .cfg_bp, .cfg_ctrlmode,
    .txwr_empty, .txwr_head, .txrd_empty, .txrd_head,
    .txrr_empty, .txrr_head,
    .etx_wait, .etx_wr_wait, .etx_rd_wait,
    .txwr_pop, .txrd_pop, .txrr_pop,
    .etx_access, .etx_packet, .etx_rr
  );

endmodule

// File: testbench/etx_sva.sv
// ##########################################################################
// Concurrent assertions for the transmit arbiter
// Pop encoding, output hold under etx_wait, no pop from an empty FIFO
// ##########################################################################

`timescale 1ns/1ns

module etx_sva (
  input logic                       tx_lclk_div4,
  input logic                       reset,
  input logic                       txwr_pop,
  input logic                       txrd_pop,
  input logic                       txrr_pop,
  input logic                       txwr_empty,
  input logic                       txrd_empty,
  input logic                       txrr_empty,
  input logic                       etx_access,
  input logic                       etx_wait,
  input logic [etx_pkt_pkg::pw-1:0] etx_packet
);

  // At most one channel popped per cycle
  pop_onehot: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    $onehot0({txwr_pop, txrd_pop, txrr_pop}))
    else $error("more than one FIFO popped in a cycle");

  // Held output keeps its packet
  out_hold: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    etx_access && etx_wait |=> $stable(etx_packet))
    else $error("etx_packet changed while etx_wait held the output");

  pop_not_empty: assert property (@(posedge tx_lclk_div4) disable iff (reset)
    (txwr_pop |-> !txwr_empty) and (txrd_pop |-> !txrd_empty) and
    (txrr_pop |-> !txrr_empty))
    else $error("pop issued to an empty FIFO");

endmodule

bind etx_arbiter etx_sva u_sva (
  .tx_lclk_div4(tx_lclk_div4), .reset(reset),
  .txwr_pop(txwr_pop), .txrd_pop(txrd_pop), .txrr_pop(txrr_pop),
  .txwr_empty(txwr_empty), .txrd_empty(txrd_empty), .txrr_empty(txrr_empty),
  .etx_access(etx_access), .etx_wait(etx_wait), .etx_packet(etx_packet)
);

// File: testbench/tb_etx.sv
// ##########################################################################
// Testbench for the eMesh transmit top level
// Clock and reset, stimulus table applied per row, xorshift payloads,
// APB access tasks, typed compare tasks and a cycle-count timeout
// ##########################################################################

`timescale 1ns/1ns

module tb_etx;

  import etx_pkt_pkg::*;
  import etx_cfg_pkg::*;

  // One stimulus row
  typedef struct {
    string      name;
    logic       bp;
    logic [3:0] mode;
    int         n_wr;
    int         n_rd;
    int         n_rr;
    logic       toggle;
  } row_t;

  localparam int n_rows = 6;

  logic              tx_lclk_div4;
  logic              reset;
  logic              txwr_push;
  logic              txrd_push;
  logic              txrr_push;
  logic [pw-1:0]     txwr_in;
  logic [pw-1:0]     txrd_in;
  logic [pw-1:0]     txrr_in;
  logic              txwr_full;
  logic              txrd_full;
  logic              txrr_full;
  logic              etx_access;
  logic [pw-1:0]     etx_packet;
  logic              etx_rr;
  logic              etx_wait;
  logic              etx_wr_wait;
  logic              etx_rd_wait;
  logic [apb_aw-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [apb_dw-1:0] pwdata;
  logic [apb_dw-1:0] prdata;
  logic              pready;

  row_t          rows [n_rows];
  logic [31:0]   rng_state = 32'd22941;
  string         cur_name = "reset";
  int            got = 0;
  int            cycles = 0;
  int            cycle_limit = 1000;
  // Expected link traffic, in send order
  logic [pw-1:0] exp_pkt [$];
  logic          exp_rr [$];

  etx_top uut (.*);

  // 100 ns clock
  initial tx_lclk_div4 = 1'b0;
  always #50 tx_lclk_div4 = ~tx_lclk_div4;

  // ########################################################################
  // Helpers
  // ########################################################################

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Stopped at first error");
  endtask

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [pw-1:0] random_packet();
    logic [pw-1:0] p;
    logic [31:0]   r;
    p[31:0]  = next_rand();
    p[63:32] = next_rand();
    p[95:64] = next_rand();
    r = next_rand();
    p[103:96] = r[7:0];
    return p;
  endfunction

  // Bypass masks in the programmed ctrlmode on slave packets
  function automatic logic [pw-1:0] expected_packet(input logic [pw-1:0] pkt,
                                                    input logic bp, input logic [3:0] mode);
    logic [pw-1:0] mask;
    mask = pw'(4'hf) << ctrlmode_lsb;
    if (bp)
      return (pkt & ~mask) | (pw'(mode) << ctrlmode_lsb);
    return pkt;
  endfunction

  task automatic check_packet(input string name, input logic [pw-1:0] exp,
                              input logic [pw-1:0] act);
    if (exp !== act)
      abort_run($sformatf("Fail %s packet: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_rr_flag(input string name, input logic exp, input logic act);
    if (exp !== act)
      abort_run($sformatf("Fail %s etx_rr: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_full(input string name, input logic exp, input logic act);
    if (exp !== act)
      abort_run($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_count(input string name, input logic [apb_dw-1:0] exp,
                             input logic [apb_dw-1:0] act);
    if (exp !== act)
      abort_run($sformatf("Fail %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // APB setup then access phase, no wait states
  task automatic apb_write(input logic [apb_aw-1:0] addr, input logic [apb_dw-1:0] data);
    @(posedge tx_lclk_div4);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge tx_lclk_div4);
    penable <= 1'b1;
    @(posedge tx_lclk_div4);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [apb_aw-1:0] addr, output logic [apb_dw-1:0] data);
    @(posedge tx_lclk_div4);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge tx_lclk_div4);
    penable <= 1'b1;
    // Read data valid mid access phase
    @(negedge tx_lclk_div4);
    if (pready !== 1'b1)
      abort_run("APB pready was not high during the access phase");
    data = prdata;
    @(posedge tx_lclk_div4);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // ########################################################################
  // Link monitor and timeout
  // ########################################################################

  // Transfer completes at the next rising edge
  always @(negedge tx_lclk_div4)
  begin
    if (!reset && etx_access && !etx_wait)
    begin
      if (exp_pkt.size() == 0)
        abort_run($sformatf("%s: packet %h sent when none was expected", cur_name, etx_packet));
      else
      begin
        check_packet($sformatf("%s #%0d", cur_name, got), exp_pkt[0], etx_packet);
        check_rr_flag($sformatf("%s #%0d", cur_name, got), exp_rr[0], etx_rr);
        exp_pkt.delete(0);
        exp_rr.delete(0);
        got++;
      end
    end
  end

  always @(posedge tx_lclk_div4)
  begin
    cycles++;
    if (cycles > cycle_limit)
      abort_run($sformatf("Timeout, run did not finish within %0d cycles", cycle_limit));
  end

  // ########################################################################
  // One table row
  // ########################################################################

  task automatic run_row(input row_t row);
    logic [pw-1:0]     pkt;
    logic [pw-1:0]     wr_q [$];
    logic [pw-1:0]     rd_q [$];
    logic [pw-1:0]     rr_q [$];
    logic [apb_dw-1:0] rdata;
    logic [31:0]       r;
    cur_name = row.name;
    got = 0;
    apb_write(reg_ctrl, (apb_dw'(row.mode) << ctrl_mode_lsb) | apb_dw'(row.bp));
    // Hold the link so that all channels fill first
    @(posedge tx_lclk_div4);
    etx_wr_wait <= 1'b1;
    etx_rd_wait <= 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      @(posedge tx_lclk_div4);
      txwr_push <= (i < row.n_wr);
      txrd_push <= (i < row.n_rd);
      txrr_push <= (i < row.n_rr);
      pkt = random_packet();
      txwr_in <= pkt;
      if (i < row.n_wr)
        wr_q.push_back(pkt);
      pkt = random_packet();
      txrd_in <= pkt;
      if (i < row.n_rd)
        rd_q.push_back(pkt);
      pkt = random_packet();
      txrr_in <= pkt;
      if (i < row.n_rr)
        rr_q.push_back(pkt);
    end
    @(posedge tx_lclk_div4);
    txwr_push <= 1'b0;
    txrd_push <= 1'b0;
    txrr_push <= 1'b0;
    // Four packets fill a default-depth FIFO
    @(negedge tx_lclk_div4);
    check_full({row.name, " txwr_full"}, row.n_wr == 4, txwr_full);
    check_full({row.name, " txrd_full"}, row.n_rd == 4, txrd_full);
    check_full({row.name, " txrr_full"}, row.n_rr == 4, txrr_full);
    // Fixed priority, so the channels drain one after the other
    foreach (wr_q[i])
    begin
      exp_pkt.push_back(expected_packet(wr_q[i], row.bp, row.mode));
      exp_rr.push_back(1'b0);
    end
    foreach (rd_q[i])
    begin
      exp_pkt.push_back(expected_packet(rd_q[i], row.bp, row.mode));
      exp_rr.push_back(1'b0);
    end
    foreach (rr_q[i])
    begin
      exp_pkt.push_back(rr_q[i]);
      exp_rr.push_back(1'b1);
    end
    @(posedge tx_lclk_div4);
    etx_wr_wait <= 1'b0;
    etx_rd_wait <= 1'b0;
    while (exp_pkt.size() > 0)
    begin
      @(posedge tx_lclk_div4);
      r = next_rand();
      etx_wait <= row.toggle & r[0];
    end
    @(posedge tx_lclk_div4);
    etx_wait <= 1'b0;
    while (etx_access)
      @(posedge tx_lclk_div4);
    // Idle cycles, any late packet is flagged by the monitor
    repeat (3) @(posedge tx_lclk_div4);
    apb_read(reg_cnt_wr, rdata);
    check_count({row.name, " reg_cnt_wr"}, apb_dw'(row.n_wr), rdata);
    apb_read(reg_cnt_rd, rdata);
    check_count({row.name, " reg_cnt_rd"}, apb_dw'(row.n_rd), rdata);
    apb_read(reg_cnt_rr, rdata);
    check_count({row.name, " reg_cnt_rr"}, apb_dw'(row.n_rr), rdata);
    apb_write(reg_cnt_wr, '0);
    apb_write(reg_cnt_rd, '0);
    apb_write(reg_cnt_rr, '0);
  endtask

  // ########################################################################
  // Main sequence
  // ########################################################################

  initial
  begin
    int total;
    // name, bypass, ctrlmode, wr, rd, rr, etx_wait toggles
    rows[0] = '{"plain_full", 1'b0, 4'h0, 4, 4, 4, 1'b0};
    rows[1] = '{"bypass_a", 1'b1, 4'ha, 3, 2, 4, 1'b0};
    rows[2] = '{"bypass_toggle", 1'b1, 4'h5, 4, 4, 4, 1'b1};
    rows[3] = '{"plain_toggle", 1'b0, 4'hf, 2, 3, 1, 1'b1};
    rows[4] = '{"wr_only", 1'b1, 4'h3, 4, 0, 0, 1'b0};
    rows[5] = '{"rr_only_bypass", 1'b1, 4'hc, 0, 0, 3, 1'b1};
    total = 0;
    foreach (rows[i])
      total += rows[i].n_wr + rows[i].n_rd + rows[i].n_rr;
    cycle_limit = 40 * total + 200;
    reset       = 1'b1;
    txwr_push   = 1'b0;
    txrd_push   = 1'b0;
    txrr_push   = 1'b0;
    txwr_in     = '0;
    txrd_in     = '0;
    txrr_in     = '0;
    etx_wait    = 1'b0;
    etx_wr_wait = 1'b0;
    etx_rd_wait = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    repeat (10) @(posedge tx_lclk_div4);
    reset <= 1'b0;
    @(negedge tx_lclk_div4);
    if (etx_access !== 1'b0)
      abort_run("etx_access was not low after reset");
    check_packet("reset", '0, etx_packet);
    check_rr_flag("reset", 1'b0, etx_rr);
    foreach (rows[i])
      run_row(rows[i]);
    $display("Testbench passed");
    $finish;
  end

endmodule
